/* logic/io_pkg.sv */
package io_pkg;

   // Bus and port widths
   localparam int DATA_W = 32;
   localparam int SEL_W  = 9;      // One-hot selects on paddr[12:4]
   localparam int GPIO_W = 8;
   localparam int LED_W  = 3;      // Red, green, blue

   // Select bit positions
   // Register n answers to address bit 4+n
   localparam int SEL_GPIO      = 0;
   localparam int SEL_EXAMPLE   = 1;
   localparam int SEL_FEEDBACK  = 2;   // Read only
   localparam int SEL_LEDS      = 3;
   localparam int SEL_SDM_RED   = 4;
   localparam int SEL_SDM_GREEN = 5;
   localparam int SEL_SDM_BLUE  = 6;
   localparam int SEL_TICKS     = 7;
   localparam int SEL_RELOAD    = 8;

   // Atomic write modifier from paddr[3:2]
   typedef enum logic [1:0] {
      OP_WRITE  = 2'b00,   // Offset +0
      OP_CLEAR  = 2'b01,   // Offset +4
      OP_SET    = 2'b10,   // Offset +8
      OP_TOGGLE = 2'b11    // Offset +12
   } io_op_e;

   // Same address word seen raw or split into its fields
   typedef union packed {
      logic [DATA_W-1:0] raw;
      struct packed {
         logic [DATA_W-SEL_W-5:0] unused;     // Upper bits not decoded
         logic [SEL_W-1:0]        sel;        // One-hot register select
         io_op_e                  op;
         logic [1:0]              byte_ofs;   // Byte lanes come from pstrb instead
      } fields;
   } io_addr_u;

endpackage

/* logic/apb_io_slave.sv */
`timescale 1ns/1ps

module apb_io_slave (
   input  logic                          clk,
   input  logic                          reset_button,

   // APB side
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [io_pkg::DATA_W-1:0]     paddr,
   input  logic [io_pkg::DATA_W-1:0]     pwdata,
   input  logic [3:0]                    pstrb,
   output logic                          pready,
   output logic [io_pkg::DATA_W-1:0]     prdata,

   // Register bank side
   output logic [io_pkg::SEL_W-1:0]      reg_sel,
   output io_pkg::io_op_e                reg_op,
   output logic                          reg_wr,
   output logic [3:0]                    reg_strb,
   output logic [io_pkg::DATA_W-1:0]     reg_wdata,
   input  logic [io_pkg::DATA_W-1:0]     reg_rdata
);

   io_pkg::io_addr_u addr;   // Decoded view of paddr
   logic             access;      // APB access phase
   logic             rd_first;    // First access cycle of a read
   logic             rd_wait;     // Read wait state, one cycle

   assign addr.raw = paddr;

   // Select and modifier straight from the address fields
   assign reg_sel   = addr.fields.sel;
   assign reg_op    = addr.fields.op;
   assign reg_strb  = pstrb;
   assign reg_wdata = pwdata;

   assign access   = psel & penable;
   assign rd_first = access & ~pwrite & ~rd_wait;

   // Writes finish in their first access cycle, so the strobe is one cycle wide
   assign reg_wr = access & pwrite;

   // Write ready at once, read ready after the wait state
   assign pready = reg_wr | rd_wait;

   always_ff @(posedge clk)
   begin
      if (reset_button)
         rd_wait <= 1'b0;
      else
         rd_wait <= rd_first;   // Drops again in the cycle pready is high
   end

   // Register read data as seen in the first access cycle
   always_ff @(posedge clk)
   begin
      if (rd_first)
         prdata <= reg_rdata;
   end

endmodule

/* logic/io_register_bank.sv */
`timescale 1ns/1ps

module io_register_bank #(
   parameter int SDM_W = 16
) (
   input  logic                          clk,
   input  logic                          reset_button,

   // From the bus slave
   input  logic [io_pkg::SEL_W-1:0]      reg_sel,
   input  io_pkg::io_op_e                reg_op,
   input  logic                          reg_wr,
   input  logic [3:0]                    reg_strb,
   input  logic [io_pkg::DATA_W-1:0]     reg_wdata,
   output logic [io_pkg::DATA_W-1:0]     reg_rdata,

   // GPIO pins
   input  logic [io_pkg::GPIO_W-1:0]     gpio_in,
   output logic [io_pkg::GPIO_W-1:0]     gpio_out,
   output logic [io_pkg::GPIO_W-1:0]     gpio_oe,

   // Timer
   input  logic [io_pkg::DATA_W-1:0]     ticks,
   input  logic [io_pkg::DATA_W-1:0]     reload,
   output logic                          timer_load_ticks,
   output logic                          timer_load_reload,
   output logic [io_pkg::DATA_W-1:0]     timer_wdata,

   // LED modulator levels
   output logic [io_pkg::LED_W-1:0]      leds,
   output logic [SDM_W-1:0]              sdm_red,
   output logic [SDM_W-1:0]              sdm_green,
   output logic [SDM_W-1:0]              sdm_blue
);

   localparam int DW = io_pkg::DATA_W;
   localparam int GW = io_pkg::GPIO_W;

   logic [GW-1:0] gpio_in_q;    // Pin state, one cycle late
   logic [DW-1:0] example;      // Free scratch register
   logic [DW-1:0] feedback;     // Shift-xor view of example
   logic [DW-1:0] modified;     // Word after clear/set/toggle
   logic          word_wr;      // Write to a whole-word register

   assign feedback = example ^ (example >> 1);

   // One-hot selects, so the read mux is a plain OR
   assign reg_rdata =
      (reg_sel[io_pkg::SEL_GPIO]      ? DW'({gpio_oe, gpio_out, gpio_in_q}) : '0) |
      (reg_sel[io_pkg::SEL_EXAMPLE]   ? example                             : '0) |
      (reg_sel[io_pkg::SEL_FEEDBACK]  ? feedback                            : '0) |
      (reg_sel[io_pkg::SEL_LEDS]      ? DW'(leds)                           : '0) |
      (reg_sel[io_pkg::SEL_SDM_RED]   ? DW'(sdm_red)                        : '0) |
      (reg_sel[io_pkg::SEL_SDM_GREEN] ? DW'(sdm_green)                      : '0) |
      (reg_sel[io_pkg::SEL_SDM_BLUE]  ? DW'(sdm_blue)                       : '0) |
      (reg_sel[io_pkg::SEL_TICKS]     ? ticks                               : '0) |
      (reg_sel[io_pkg::SEL_RELOAD]    ? reload                              : '0);

   // Atomic bit operations against the current register value
   always_comb
   begin
      case (reg_op)
         io_pkg::OP_CLEAR:  modified = reg_rdata & ~reg_wdata;
         io_pkg::OP_SET:    modified = reg_rdata | reg_wdata;
         io_pkg::OP_TOGGLE: modified = reg_rdata ^ reg_wdata;
         default:           modified = reg_wdata;   // Plain write
      endcase
   end

   // Word registers take any byte strobe as a full write
   assign word_wr = reg_wr & (|reg_strb);

   // Timer keeps its own registers and just gets load strobes
   assign timer_load_ticks  = word_wr & reg_sel[io_pkg::SEL_TICKS];
   assign timer_load_reload = word_wr & reg_sel[io_pkg::SEL_RELOAD];
   assign timer_wdata       = modified;

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         gpio_in_q <= '0;
         gpio_out  <= '0;
         gpio_oe   <= '0;
         example   <= '0;
         leds      <= '0;
         sdm_red   <= '0;
         sdm_green <= '0;
         sdm_blue  <= '0;
      end
      else
      begin
         gpio_in_q <= gpio_in;

         // GPIO byte 0 is the input and not writable
         if (reg_wr & reg_sel[io_pkg::SEL_GPIO] & reg_strb[1])
            gpio_out <= modified[2*GW-1:GW];
         if (reg_wr & reg_sel[io_pkg::SEL_GPIO] & reg_strb[2])
            gpio_oe <= modified[3*GW-1:2*GW];   // Direction, 1 drives the pin

         // Example register honours every byte lane
         for (int b = 0; b < 4; b++)
         begin
            if (reg_wr & reg_sel[io_pkg::SEL_EXAMPLE] & reg_strb[b])
               example[8*b +: 8] <= modified[8*b +: 8];
         end

         if (word_wr & reg_sel[io_pkg::SEL_LEDS])      leds      <= modified[io_pkg::LED_W-1:0];
         if (word_wr & reg_sel[io_pkg::SEL_SDM_RED])   sdm_red   <= modified[SDM_W-1:0];
         if (word_wr & reg_sel[io_pkg::SEL_SDM_GREEN]) sdm_green <= modified[SDM_W-1:0];
         if (word_wr & reg_sel[io_pkg::SEL_SDM_BLUE])  sdm_blue  <= modified[SDM_W-1:0];
      end
   end

endmodule

/* logic/interval_timer.sv */
`timescale 1ns/1ps

module interval_timer (
   input  logic                          clk,
   input  logic                          reset_button,

   // Loads from the register bank
   input  logic                          timer_load_ticks,
   input  logic                          timer_load_reload,
   input  logic [io_pkg::DATA_W-1:0]     timer_wdata,

   output logic [io_pkg::DATA_W-1:0]     ticks,
   output logic [io_pkg::DATA_W-1:0]     reload,
   output logic                          irq     // One cycle per overflow
);

   logic [io_pkg::DATA_W:0]   ticks_plus_1;   // Extra bit is the overflow
   logic [io_pkg::DATA_W-1:0] next_ticks;

   assign ticks_plus_1 = {1'b0, ticks} + 1'b1;

   // Wrap to the reload value instead of zero
   assign next_ticks = ticks_plus_1[io_pkg::DATA_W] ? reload
                                                    : ticks_plus_1[io_pkg::DATA_W-1:0];

   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         ticks  <= '0;
         reload <= '0;
         irq    <= 1'b0;
      end
      else
      begin
         // Software load wins over counting
         if (timer_load_ticks)
            ticks <= timer_wdata;
         else
            ticks <= next_ticks;

         if (timer_load_reload)
            reload <= timer_wdata;

         irq <= ticks_plus_1[io_pkg::DATA_W];   // Pulse the cycle after all ones
      end
   end

endmodule

/* logic/sdm_led_driver.sv */
`timescale 1ns/1ps

module sdm_led_driver #(
   parameter int SDM_W = 16
) (
   input  logic                          clk,
   input  logic                          reset_button,
   input  logic [io_pkg::LED_W-1:0]      leds,        // Static on bits
   input  logic [SDM_W-1:0]              sdm_red,
   input  logic [SDM_W-1:0]              sdm_green,
   input  logic [SDM_W-1:0]              sdm_blue,
   output logic [io_pkg::LED_W-1:0]      led_out
);

   logic [SDM_W-1:0]         level [io_pkg::LED_W];   // Brightness per channel
   logic [SDM_W-1:0]         phase [io_pkg::LED_W];   // Accumulators
   logic [io_pkg::LED_W-1:0] carry;                   // Modulator bit stream

   // Channel order matches led_out
   assign level[0] = sdm_red;
   assign level[1] = sdm_green;
   assign level[2] = sdm_blue;

   // First order modulator, carry density is level / 2**SDM_W
   always_ff @(posedge clk)
   begin
      if (reset_button)
      begin
         for (int i = 0; i < io_pkg::LED_W; i++)
         begin
            phase[i] <= '0;
            carry[i] <= 1'b0;
         end
      end
      else
      begin
         for (int i = 0; i < io_pkg::LED_W; i++)
            {carry[i], phase[i]} <= {1'b0, phase[i]} + {1'b0, level[i]};
      end
   end

   assign led_out = carry | leds;   // LED bit forces the channel on

endmodule

/* logic/io_playground_top.sv */
`timescale 1ns/1ps

module io_playground_top #(
   parameter int SDM_W = 16   // Modulator resolution
) (
   input  logic                          clk,
   input  logic                          reset_button,

   // APB slave port
   input  logic                          psel,
   input  logic                          penable,
   input  logic                          pwrite,
   input  logic [io_pkg::DATA_W-1:0]     paddr,
   input  logic [io_pkg::DATA_W-1:0]     pwdata,
   input  logic [3:0]                    pstrb,
   output logic                          pready,
   output logic [io_pkg::DATA_W-1:0]     prdata,

   // Pins
   input  logic [io_pkg::GPIO_W-1:0]     gpio_in,
   output logic [io_pkg::GPIO_W-1:0]     gpio_out,
   output logic [io_pkg::GPIO_W-1:0]     gpio_oe,
   output logic [io_pkg::LED_W-1:0]      led_out,   // [0] red [1] green [2] blue
   output logic                          irq
);

   // Slave to bank
   logic [io_pkg::SEL_W-1:0]  reg_sel;
   io_pkg::io_op_e            reg_op;
   logic                      reg_wr;
   logic [3:0]                reg_strb;
   logic [io_pkg::DATA_W-1:0] reg_wdata;
   logic [io_pkg::DATA_W-1:0] reg_rdata;

   // Bank and timer
   logic                      timer_load_ticks;
   logic                      timer_load_reload;
   logic [io_pkg::DATA_W-1:0] timer_wdata;
   logic [io_pkg::DATA_W-1:0] ticks;
   logic [io_pkg::DATA_W-1:0] reload;

   // Bank to modulators
   logic [io_pkg::LED_W-1:0]  leds;
   logic [SDM_W-1:0]          sdm_red;
   logic [SDM_W-1:0]          sdm_green;
   logic [SDM_W-1:0]          sdm_blue;

   apb_io_slave u_apb (
      .clk, .reset_button,
      .psel, .penable, .pwrite, .paddr, .pwdata, .pstrb, .pready, .prdata,
      .reg_sel, .reg_op, .reg_wr, .reg_strb, .reg_wdata, .reg_rdata
   );

   io_register_bank #(.SDM_W(SDM_W)) u_regs (
      .clk, .reset_button,
      .reg_sel, .reg_op, .reg_wr, .reg_strb, .reg_wdata, .reg_rdata,
      .gpio_in, .gpio_out, .gpio_oe,
      .ticks, .reload, .timer_load_ticks, .timer_load_reload, .timer_wdata,
      .leds, .sdm_red, .sdm_green, .sdm_blue
   );

   interval_timer u_timer (
      .clk, .reset_button,
      .timer_load_ticks, .timer_load_reload, .timer_wdata,
      .ticks, .reload, .irq
   );

   sdm_led_driver #(.SDM_W(SDM_W)) u_sdm (
      .clk, .reset_button,
      .leds, .sdm_red, .sdm_green, .sdm_blue,
      .led_out
   );

endmodule

/* tests/io_checker.sv */
`timescale 1ns/1ps

module io_checker #(
   parameter int SDM_W = 16
) (
   input  logic        clk,
   input  logic        reset_button,
   input  logic        psel, penable, pwrite,
   input  logic [31:0] paddr, pwdata,
   input  logic [3:0]  pstrb,
   input  logic        pready,
   input  logic [31:0] prdata,
   input  logic [7:0]  gpio_in, gpio_out, gpio_oe,
   input  logic [2:0]  led_out,
   input  logic        irq,
   input  logic        measure,      // Count led_out pulses while high
   output int          check_count,
   output int          error_count
);

   logic [7:0]       gin_m, gpo_m, goe_m;       // GPIO model, input one cycle late
   logic [31:0]      ex_m, ticks_m, reload_m;
   logic [31:0]      exp_rd, old_v, mod, t_old, r_old;
   logic [2:0]       leds_m;
   logic [SDM_W-1:0] lvl_m [3];                  // Red, green, blue levels
   logic             irq_m, rd_pending, meas_q, load_ticks;
   int               hits [3];

   initial
   begin
      check_count = 0;
      error_count = 0;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      check_count++;
      if (got !== exp)
      begin
         error_count++;
         $display("Mismatch %s: got %h, expected %h", name, got, exp);
      end
   endtask

   // Read value of the model for a one-hot select
   function automatic logic [31:0] model_read(input logic [8:0] sel);
      logic [31:0] v;
      v = '0;
      if (sel[io_pkg::SEL_GPIO])     v |= {8'h00, goe_m, gpo_m, gin_m};
      if (sel[io_pkg::SEL_EXAMPLE])  v |= ex_m;
      if (sel[io_pkg::SEL_FEEDBACK]) v |= ex_m ^ (ex_m >> 1);
      if (sel[io_pkg::SEL_LEDS])     v |= 32'(leds_m);
      for (int k = 0; k < 3; k++)
         if (sel[io_pkg::SEL_SDM_RED + k]) v |= 32'(lvl_m[k]);
      if (sel[io_pkg::SEL_TICKS])    v |= ticks_m;
      if (sel[io_pkg::SEL_RELOAD])   v |= reload_m;
      return v;
   endfunction

   always @(posedge clk)
   begin
      if (reset_button)
      begin
         {gin_m, gpo_m, goe_m, leds_m, irq_m, rd_pending, meas_q} = '0;
         ex_m     = '0;
         ticks_m  = '0;
         reload_m = '0;
         lvl_m    = '{default: '0};
      end
      else
      begin
         check("irq", irq, irq_m);                // Outputs as they stand before the edge
         check("gpio_out", gpio_out, gpo_m);
         check("gpio_oe", gpio_oe, goe_m);
         t_old      = ticks_m;
         r_old      = reload_m;
         load_ticks = 1'b0;
         if (psel && penable && !pwrite)
         begin
            check("pready", pready, rd_pending);   // Ready only in the wait state
            if (!rd_pending)
               exp_rd = model_read(paddr[12:4]); // Data as held in the first access cycle
            else
               check("prdata", prdata, exp_rd);
            rd_pending = !rd_pending;
         end
         else if (psel && penable)
         begin
            check("pready", pready, 1'b1);         // Writes take no wait state
            old_v = model_read(paddr[12:4]);
            case (paddr[3:2])
               2'd1:    mod = old_v & ~pwdata;     // Clear
               2'd2:    mod = old_v | pwdata;      // Set
               2'd3:    mod = old_v ^ pwdata;      // Toggle
               default: mod = pwdata;
            endcase
            if (paddr[4] && pstrb[1]) gpo_m = mod[15:8];
            if (paddr[4] && pstrb[2]) goe_m = mod[23:16];
            for (int b = 0; b < 4; b++)
               if (paddr[5] && pstrb[b]) ex_m[8*b +: 8] = mod[8*b +: 8];
            if (|pstrb)
            begin
               // Whole-word registers
               if (paddr[7]) leds_m = mod[2:0];
               for (int k = 0; k < 3; k++)
                  if (paddr[8+k]) lvl_m[k] = mod[SDM_W-1:0];
               if (paddr[12]) reload_m = mod;
               load_ticks = paddr[11];
            end
         end
         else
            check("pready", pready, 1'b0);
         ticks_m = load_ticks ? mod : (t_old == '1 ? r_old : t_old + 1);
         irq_m   = (t_old == '1);                  // Overflow shows one cycle later
         gin_m   = gpio_in;

         // Brightness window, one full modulator period
         if (measure && !meas_q)
            hits = '{default: 0};
         if (measure)
            for (int i = 0; i < 3; i++)
               hits[i] += led_out[i];
         if (!measure && meas_q)
            for (int i = 0; i < 3; i++)
               check($sformatf("led_out[%0d] count", i), hits[i],
                     leds_m[i] ? 32'(1 << SDM_W) : 32'(lvl_m[i]));
         meas_q = measure;
      end
   end

endmodule

/* tests/tb_top.sv */
`timescale 1ns/1ps

module tb_top;

   localparam int SDM_W = 16;

   logic        clk = 1'b0;
   logic        reset_button;
   logic        psel, penable, pwrite, pready, irq, measure;
   logic [31:0] paddr, pwdata, prdata;
   logic [3:0]  pstrb;
   logic [7:0]  gpio_in, gpio_out, gpio_oe;
   logic [2:0]  led_out;
   logic [31:0] rng = 32'd41;       // Xorshift state
   int          check_count, error_count;
   int          tb_errors = 0;      // Timeouts and missing pulses
   int          reported = 0;

   always #5 clk = ~clk;

   io_playground_top #(.SDM_W(SDM_W)) dut (.*);

   io_checker #(.SDM_W(SDM_W)) chk (.*);

   function automatic logic [31:0] next_random();
      rng ^= rng << 13;
      rng ^= rng >> 17;
      rng ^= rng << 5;
      return rng;
   endfunction

   // Random upper and byte offset bits, which the slave ignores
   function automatic logic [31:0] reg_addr(input int sel, input int op);
      return (next_random() & 32'hffff_e003) | (32'd1 << (4 + sel)) | 32'(op << 2);
   endfunction

   task automatic apb_access(input logic wr, input logic [31:0] addr,
                             input logic [31:0] data, input logic [3:0] strb);
      int waits;
      @(negedge clk);
      psel    = 1'b1;               // Setup phase
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = data;
      pstrb   = strb;
      @(negedge clk);
      penable = 1'b1;
      waits   = 0;
      @(posedge clk);
      while (!pready && waits < 8)
      begin
         waits++;
         @(posedge clk);
      end
      if (!pready)
      begin
         tb_errors++;
         $display("No pready within 8 cycles for address %h", addr);
      end
      @(negedge clk);
      psel    = 1'b0;
      penable = 1'b0;
   endtask

   task automatic write_reg(input int sel, input int op, input logic [31:0] data,
                            input logic [3:0] strb);
      apb_access(1'b1, reg_addr(sel, op), data, strb);
   endtask

   task automatic read_reg(input int sel);
      apb_access(1'b0, reg_addr(sel, 0), '0, '0);
   endtask

   task automatic measure_leds();
      repeat (3) @(negedge clk);    // Last level write reaches the carries
      measure = 1'b1;
      repeat (1 << SDM_W) @(negedge clk);
      measure = 1'b0;
      @(negedge clk);
   endtask

   task automatic end_test(input string name);
      $display("%s: %0d errors", name, error_count + tb_errors - reported);
      reported = error_count + tb_errors;
   endtask

   initial
   begin
      logic [31:0] v;
      int          n;
      {psel, penable, pwrite, measure} = '0;
      paddr        = '0;
      pwdata       = '0;
      pstrb        = '0;
      gpio_in      = '0;
      reset_button = 1'b1;
      repeat (2) @(negedge clk);
      reset_button = 1'b0;

      // GPIO, example, feedback and LEDs with all four operations
      repeat (200)
      begin
         v       = next_random();
         gpio_in = v[31:24];
         if (v[0])
            write_reg(v[2:1], v[4:3], next_random(), v[8:5]);
         else
            read_reg(v[2:1]);
      end
      end_test("random register access");

      repeat (20)
      begin
         v = next_random();
         write_reg(io_pkg::SEL_GPIO, v[1:0], v, 4'b0110);
         v       = next_random();
         gpio_in = v[7:0];
         repeat (2) @(negedge clk);   // Input settles through its register
         read_reg(io_pkg::SEL_GPIO);
      end
      end_test("gpio outputs and input");

      for (int k = 0; k < 3; k++)
         write_reg(io_pkg::SEL_SDM_RED + k, io_pkg::OP_WRITE, next_random(), 4'hf);
      write_reg(io_pkg::SEL_LEDS, io_pkg::OP_WRITE, '0, 4'hf);
      measure_leds();
      write_reg(io_pkg::SEL_LEDS, io_pkg::OP_SET, next_random() | 32'd1, 4'h1);
      measure_leds();
      end_test("modulator brightness");

      write_reg(io_pkg::SEL_RELOAD, io_pkg::OP_WRITE, next_random() >> 1, 4'hf);
      write_reg(io_pkg::SEL_TICKS, io_pkg::OP_WRITE, 32'hffff_ffff - next_random() % 50, 4'hf);
      n = 0;
      while (!irq && n < 100)
      begin
         n++;
         @(posedge clk);
      end
      if (!irq)
      begin
         tb_errors++;
         $display("irq did not pulse within 100 cycles of the ticks write");
      end
      read_reg(io_pkg::SEL_TICKS);
      read_reg(io_pkg::SEL_RELOAD);
      end_test("timer reload and interrupt");

      @(negedge clk);
      reset_button = 1'b1;
      repeat (2) @(negedge clk);
      reset_button = 1'b0;
      for (int s = 0; s < io_pkg::SEL_W; s++)
         read_reg(s);
      measure_leds();               // Zero levels keep every LED dark
      end_test("reset state");

      $display("%0d checks, %0d errors", check_count, error_count + tb_errors);
      if (error_count + tb_errors == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

/* filelist.f */
logic/io_pkg.sv
logic/apb_io_slave.sv
logic/io_register_bank.sv
logic/interval_timer.sv
logic/sdm_led_driver.sv
logic/io_playground_top.sv
tests/io_checker.sv
tests/tb_top.sv

/* Bender.yml */
package:
  name: io_playground

sources:
  - logic/io_pkg.sv
  - logic/apb_io_slave.sv
  - logic/io_register_bank.sv
  - logic/interval_timer.sv
  - logic/sdm_led_driver.sv
  - logic/io_playground_top.sv
  - target: test
    files:
      - tests/io_checker.sv
      - tests/tb_top.sv
